/* Makefile */
TOP = tb_nb_cache

all: run

run:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* sim.f */
src/cache_pkg.sv
src/req_fifo.sv
src/lookup_pipe.sv
src/tag_data_store.sv
src/nb_cache.sv
tests/cache_checker.sv
tests/tb_nb_cache.sv

/* src/cache_pkg.sv */
package cache_pkg;

	// address split, from the top bit down: tag, set index, word in block
	localparam int TAG_W = 3;
	localparam int INDEX_W = 4;
	localparam int BLK_W = 1;
	localparam int ADDR_W = TAG_W + INDEX_W + BLK_W;

	// cached word and the side tag that rides along with a request
	localparam int RDATA_W = 16;
	localparam int SIDE_W = 4;

	// storage read latency
	// the lookup pipeline is exactly this deep
	localparam int LOOKUP_LAT = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [RDATA_W-1:0] rdata_t;
	typedef logic [SIDE_W-1:0] side_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;

endpackage

/* src/lookup_pipe.sv */
`timescale 1ns/1ps

module lookup_pipe #(
	parameter int WIDTH = 12,
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic [WIDTH-1:0] in_data,
	output logic in_stall,
	output logic out_valid,
	output logic [WIDTH-1:0] out_data,
	input logic out_stall,
	input logic [$clog2(FIFO_DEPTH+1)-1:0] room_used
);

	localparam int LAT = cache_pkg::LOOKUP_LAT;
	// wide enough for buffer occupancy plus everything in flight
	localparam int CNT_W = $clog2(FIFO_DEPTH + LAT + 1);

	logic [LAT-1:0] stage_valid;
	logic [WIDTH-1:0] stage_data [LAT];
	logic [CNT_W-1:0] in_flight;
	logic [CNT_W-1:0] demand;
	logic take;

	// items already committed to leave the pipe
	always_comb begin
		in_flight = '0;
		for (int i = 0; i < LAT; i++) begin
			in_flight = in_flight + CNT_W'(stage_valid[i]);
		end
	end

	// worst case, nothing drains before the new item arrives
	assign demand = CNT_W'(room_used) + in_flight;
	assign in_stall = out_stall | (demand >= CNT_W'(FIFO_DEPTH));
	assign take = in_valid & ~in_stall;

	// never holds, so items stay aligned with the storage read
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_valid <= '0;
		end else begin
			stage_valid[0] <= take;
			for (int i = 1; i < LAT; i++) begin
				stage_valid[i] <= stage_valid[i-1];
			end
		end
	end

	// payload follows the valid bits
	always_ff @(posedge clk) begin
		stage_data[0] <= in_data;
		for (int i = 1; i < LAT; i++) begin
			stage_data[i] <= stage_data[i-1];
		end
	end

	assign out_valid = stage_valid[LAT-1];
	assign out_data = stage_data[LAT-1];

endmodule

/* src/nb_cache.sv */
`timescale 1ns/1ps

module nb_cache #(
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic us_valid,
	input cache_pkg::addr_t us_addr,
	input cache_pkg::side_t us_side,
	output logic us_stall,
	output cache_pkg::addr_t mh_req_addr,
	output logic mh_req_valid,
	input logic mh_req_stall,
	input cache_pkg::rdata_t mh_fill_data,
	input logic mh_fill_valid,
	output logic mh_fill_stall,
	output cache_pkg::rdata_t ds_data,
	output cache_pkg::side_t ds_side,
	output logic ds_valid,
	input logic ds_stall
);

	localparam int AW = cache_pkg::ADDR_W;
	localparam int SW = cache_pkg::SIDE_W;
	localparam int PIPE_W = AW + SW;
	localparam int HIT_W = cache_pkg::RDATA_W + SW;
	// reissue entries carry the wait flag in the low bit
	localparam int RI_W = AW + SW + 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int RB_CNT_W = $clog2(cache_pkg::LOOKUP_LAT + 1);

	// steering
	logic rif_re, us_take, fill_take, resv_full;
	// requests somewhere between the pipe entry and a hit
	logic [CNT_W-1:0] resv;

	// lookup pipe
	logic pipe_in_valid, pipe_in_stall, pipe_out_valid, pipe_out_stall;
	logic [PIPE_W-1:0] pipe_in_data, pipe_out_data;
	logic [CNT_W-1:0] room_used;
	cache_pkg::addr_t pipe_addr, blk_addr, raddr;
	cache_pkg::side_t pipe_side;

	// storage
	cache_pkg::rdata_t rdata;
	logic hit;

	// miss request, hit data, reissue buffer and reissue fifos
	logic mrf_we, mrf_empty, mrf_match;
	logic hdf_we, hdf_full, hdf_empty;
	logic [HIT_W-1:0] hdf_in, hdf_out;
	logic [CNT_W-1:0] hdf_count;
	logic rb_we, rb_re, rb_full, rb_empty;
	logic [RI_W-1:0] rb_in, rb_out;
	logic [RB_CNT_W-1:0] rb_count;
	logic rif_full, rif_empty, rif_wait;
	logic [RI_W-1:0] rif_out;
	cache_pkg::addr_t rif_addr;
	cache_pkg::side_t rif_side;

	assign {rif_addr, rif_side, rif_wait} = rif_out;

	// reissue goes first, a waiting entry needs its fill
	assign rif_re = ~rif_empty & ~pipe_in_stall & (~rif_wait | mh_fill_valid);
	assign fill_take = rif_re & rif_wait;
	assign mh_fill_stall = mh_fill_valid & ~fill_take;

	// new requests also need a reissue slot held for them
	assign resv_full = (resv >= CNT_W'(FIFO_DEPTH));
	assign us_take = us_valid & ~rif_re & ~pipe_in_stall & ~resv_full;
	assign us_stall = us_valid & ~us_take;

	assign pipe_in_valid = rif_re | us_take;
	assign pipe_in_data = rif_re ? {rif_addr, rif_side} : {us_addr, us_side};
	assign raddr = rif_re ? rif_addr : us_addr;
	assign room_used = (hdf_count > CNT_W'(rb_count)) ? hdf_count : CNT_W'(rb_count);
	assign pipe_out_stall = hdf_full | rb_full;

	// pipe output routing
	assign {pipe_addr, pipe_side} = pipe_out_data;
	assign blk_addr = {pipe_addr[AW-1:cache_pkg::BLK_W], {cache_pkg::BLK_W{1'b0}}};
	assign hdf_we = pipe_out_valid & hit;
	assign hdf_in = {rdata, pipe_side};
	assign rb_we = pipe_out_valid & ~hit;
	// wait only if this miss is the one that queued the request
	assign rb_in = {pipe_addr, pipe_side, ~mrf_match};
	assign mrf_we = rb_we & ~mrf_match;
	assign rb_re = ~rb_empty & ~rif_full;

	assign {ds_data, ds_side} = hdf_out;
	assign ds_valid = ~hdf_empty;
	assign mh_req_valid = ~mrf_empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			resv <= '0;
		else if (us_take && !hdf_we)
			resv <= resv + 1'b1;
		else if (!us_take && hdf_we)
			resv <= resv - 1'b1;
	end

	tag_data_store store_i (
		.clk, .rst, .raddr, .waddr(rif_addr), .wdata(mh_fill_data), .we(fill_take),
		.pipe_tag(pipe_addr[AW-1 -: cache_pkg::TAG_W]), .rdata, .hit
	);

	lookup_pipe #(.WIDTH(PIPE_W), .FIFO_DEPTH(FIFO_DEPTH)) pipe_i (
		.clk, .rst, .in_valid(pipe_in_valid), .in_data(pipe_in_data),
		.in_stall(pipe_in_stall), .out_valid(pipe_out_valid), .out_data(pipe_out_data),
		.out_stall(pipe_out_stall), .room_used
	);

	req_fifo #(.WIDTH(AW), .DEPTH(FIFO_DEPTH)) mrf_i (
		.clk, .rst, .data_in(blk_addr), .we(mrf_we), .re(~mh_req_stall), .full(),
		.empty(mrf_empty), .data_out(mh_req_addr), .count(), .match_key(blk_addr),
		.match(mrf_match)
	);

	req_fifo #(.WIDTH(HIT_W), .DEPTH(FIFO_DEPTH)) hdf_i (
		.clk, .rst, .data_in(hdf_in), .we(hdf_we), .re(~ds_stall), .full(hdf_full),
		.empty(hdf_empty), .data_out(hdf_out), .count(hdf_count), .match_key('0),
		.match()
	);

	req_fifo #(.WIDTH(RI_W), .DEPTH(cache_pkg::LOOKUP_LAT)) rbuf_i (
		.clk, .rst, .data_in(rb_in), .we(rb_we), .re(rb_re), .full(rb_full),
		.empty(rb_empty), .data_out(rb_out), .count(rb_count), .match_key('0),
		.match()
	);

	req_fifo #(.WIDTH(RI_W), .DEPTH(FIFO_DEPTH)) rif_i (
		.clk, .rst, .data_in(rb_out), .we(rb_re), .re(rif_re), .full(rif_full),
		.empty(rif_empty), .data_out(rif_out), .count(), .match_key('0), .match()
	);

endmodule

/* src/req_fifo.sv */
`timescale 1ns/1ps

module req_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic [WIDTH-1:0] data_in,
	input logic we,
	input logic re,
	output logic full,
	output logic empty,
	output logic [WIDTH-1:0] data_out,
	output logic [$clog2(DEPTH+1)-1:0] count,
	input logic [WIDTH-1:0] match_key,
	output logic match
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	// one flag per slot, marks entries still waiting to be read
	logic [DEPTH-1:0] occupied;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_write;
	logic do_read;

	// wrap without relying on a power of two depth
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	// writes to a full fifo and reads of an empty one are dropped
	assign do_write = we & ~full;
	assign do_read = re & ~empty;
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			occupied <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= next_ptr(wr_ptr);
				occupied[wr_ptr] <= 1'b1;
			end
			if (do_read) begin
				rd_ptr <= next_ptr(rd_ptr);
				occupied[rd_ptr] <= 1'b0;
			end
			// occupancy only moves when exactly one side is active
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= data_in;
	end

	// search every live slot for the key
	always_comb begin
		match = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (occupied[i] && mem[i] == match_key)
				match = 1'b1;
		end
	end

endmodule

/* src/tag_data_store.sv */
`timescale 1ns/1ps

module tag_data_store (
	input logic clk,
	input logic rst,
	input cache_pkg::addr_t raddr,
	input cache_pkg::addr_t waddr,
	input cache_pkg::rdata_t wdata,
	input logic we,
	input cache_pkg::tag_t pipe_tag,
	output cache_pkg::rdata_t rdata,
	output logic hit
);

	localparam int SETS = 1 << cache_pkg::INDEX_W;
	localparam int IDX_LO = cache_pkg::BLK_W;
	localparam int TAG_LO = cache_pkg::BLK_W + cache_pkg::INDEX_W;

	// two ways, one entry per set in each
	cache_pkg::rdata_t data0 [SETS];
	cache_pkg::rdata_t data1 [SETS];
	cache_pkg::tag_t tag0 [SETS];
	cache_pkg::tag_t tag1 [SETS];
	logic [SETS-1:0] valid0;
	logic [SETS-1:0] valid1;
	// round-robin victim bit per set
	logic [SETS-1:0] rr;

	cache_pkg::index_t rd_index;
	cache_pkg::index_t wr_index;
	cache_pkg::tag_t wr_tag;
	logic victim;
	logic bypass;

	// read stage a and stage b
	cache_pkg::rdata_t d0_a, d1_a, d0_b, d1_b;
	cache_pkg::tag_t t0_a, t1_a, t0_b, t1_b;
	logic v0_a, v1_a, v0_b, v1_b;
	logic hit0;
	logic hit1;

	assign rd_index = raddr[IDX_LO +: cache_pkg::INDEX_W];
	assign wr_index = waddr[IDX_LO +: cache_pkg::INDEX_W];
	assign wr_tag = waddr[TAG_LO +: cache_pkg::TAG_W];
	assign victim = rr[wr_index];
	// fill lands in the set being read this cycle
	assign bypass = we && (rd_index == wr_index);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid0 <= '0;
			valid1 <= '0;
			rr <= '0;
			v0_a <= 1'b0;
			v1_a <= 1'b0;
			v0_b <= 1'b0;
			v1_b <= 1'b0;
		end else begin
			v0_a <= valid0[rd_index];
			v1_a <= valid1[rd_index];
			if (we) begin
				if (victim)
					valid1[wr_index] <= 1'b1;
				else
					valid0[wr_index] <= 1'b1;
				// next fill to this set takes the other way
				rr[wr_index] <= ~victim;
			end
			if (bypass) begin
				if (victim)
					v1_a <= 1'b1;
				else
					v0_a <= 1'b1;
			end
			v0_b <= v0_a;
			v1_b <= v1_a;
		end
	end

	always_ff @(posedge clk) begin
		d0_a <= data0[rd_index];
		d1_a <= data1[rd_index];
		t0_a <= tag0[rd_index];
		t1_a <= tag1[rd_index];
		if (we) begin
			if (victim) begin
				data1[wr_index] <= wdata;
				tag1[wr_index] <= wr_tag;
			end else begin
				data0[wr_index] <= wdata;
				tag0[wr_index] <= wr_tag;
			end
		end
		// same cycle write wins over the array read
		if (bypass) begin
			if (victim) begin
				d1_a <= wdata;
				t1_a <= wr_tag;
			end else begin
				d0_a <= wdata;
				t0_a <= wr_tag;
			end
		end
		d0_b <= d0_a;
		d1_b <= d1_a;
		t0_b <= t0_a;
		t1_b <= t1_a;
	end

	// compare against the tag of the item leaving the pipe
	assign hit0 = v0_b && (t0_b == pipe_tag);
	assign hit1 = v1_b && (t1_b == pipe_tag);
	assign hit = hit0 | hit1;
	assign rdata = hit0 ? d0_b : d1_b;

endmodule

/* tests/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker (
	input logic clk,
	input logic rst,
	input logic us_valid,
	input logic us_stall,
	input cache_pkg::addr_t us_addr,
	input cache_pkg::side_t us_side,
	input logic mh_req_valid,
	input logic mh_req_stall,
	input cache_pkg::addr_t mh_req_addr,
	input logic mh_fill_valid,
	input logic mh_fill_stall,
	input logic ds_valid,
	input logic ds_stall,
	input cache_pkg::rdata_t ds_data,
	input cache_pkg::side_t ds_side,
	input cache_pkg::rdata_t exp_mem [128],
	input logic test_end,
	input int test_num,
	output logic [15:0] pending,
	output int tests_passed,
	output int tests_failed
);

	// request address parked on each side tag
	cache_pkg::addr_t side_addr [16];
	// blocks ever accessed, blocks seen on the miss port
	logic [127:0] seen = '0;
	logic [127:0] requested = '0;
	// blocks filled with no other block filled into their set since
	logic [127:0] resident = '0;
	// accesses that found their block absent, each may cost one miss request
	int miss_credit [128] = '{default: 0};
	// blocks sent to the miss handler, fills come back in this order
	logic [6:0] fill_wait_q [$];
	// first touches of a block during this test
	cache_pkg::addr_t cold_q [$];
	int errors = 0;
	int sent = 0;
	int got = 0;
	logic fresh = 1'b0;

	// a fill may evict any other block of its set
	task automatic note_fill(input logic [6:0] blk);
		logic [6:0] other;
		for (int i = 0; i < 8; i++) begin
			other = {3'(i), blk[3:0]};
			resident[other] = 1'b0;
		end
		resident[blk] = 1'b1;
	endtask

	task automatic close_test();
		// every cold access must have gone out as a miss
		foreach (cold_q[i]) begin
			if (!requested[cold_q[i][7:1]]) begin
				$display("test %0d: cold access to %h never reached the miss handler",
					test_num, cold_q[i]);
				errors++;
			end
		end
		if (pending != '0) begin
			$display("test %0d: responses never arrived for sides %b", test_num, pending);
			errors++;
		end
		if (sent != got) begin
			$display("test %0d: %0d requests but %0d responses", test_num, sent, got);
			errors++;
		end
		if (errors == 0) begin
			tests_passed++;
			$display("test %0d PASS, %0d responses", test_num, got);
		end else begin
			tests_failed++;
			$display("test %0d FAIL, %0d errors", test_num, errors);
		end
		cold_q.delete();
		pending = '0;
		errors = 0;
		sent = 0;
		got = 0;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			pending = '0;
			tests_passed = 0;
			tests_failed = 0;
			fresh = 1'b1;
		end else begin
			// first cycle out of reset, both valids low
			if (fresh && (ds_valid || mh_req_valid)) begin
				$display("** Error at %0t: ds_valid %b mh_req_valid %b just after reset",
					$time, ds_valid, mh_req_valid);
				errors++;
			end
			fresh = 1'b0;
			if (mh_fill_valid && !mh_fill_stall && fill_wait_q.size() > 0)
				note_fill(fill_wait_q.pop_front());
			if (mh_req_valid && !mh_req_stall) begin
				requested[mh_req_addr[7:1]] = 1'b1;
				fill_wait_q.push_back(mh_req_addr[7:1]);
				// every access to this block found it cached
				if (miss_credit[mh_req_addr[7:1]] == 0) begin
					$display("test %0d: miss request for block %h, which was still cached",
						test_num, mh_req_addr);
					errors++;
				end else begin
					miss_credit[mh_req_addr[7:1]]--;
				end
			end
			if (ds_valid && !ds_stall) begin
				got++;
				if (!pending[ds_side]) begin
					$display("response at %0t on side %0d, which had nothing outstanding",
						$time, ds_side);
					errors++;
				end else if (ds_data !== exp_mem[side_addr[ds_side][7:1]]) begin
					$display("** Error at %0t: side %0d addr %h got %h expected %h", $time,
						ds_side, side_addr[ds_side], ds_data,
						exp_mem[side_addr[ds_side][7:1]]);
					errors++;
				end
				pending[ds_side] = 1'b0;
			end
			if (us_valid && !us_stall) begin
				sent++;
				side_addr[us_side] = us_addr;
				pending[us_side] = 1'b1;
				if (!seen[us_addr[7:1]])
					cold_q.push_back(us_addr);
				seen[us_addr[7:1]] = 1'b1;
				if (!resident[us_addr[7:1]])
					miss_credit[us_addr[7:1]]++;
			end
			if (test_end)
				close_test();
		end
	end

endmodule

/* tests/cache_input.dat */
// test header: test_number request_count ds_stall_enable mh_stall_enable
// request record: address(hex) block_word(hex), one line per request
1 4 0 0
02 1a02
05 2b04
10 3c10
21 4d20
2 3 0 0
03 1a02
11 3c10
20 4d20
3 5 0 0
06 5e06
26 6f26
46 7046
07 5e06
27 6f26
4 4 1 0
e8 92e8
02 1a02
e9 92e8
67 8166
5 5 0 1
f2 c5f2
3d b43c
f3 c5f2
3c b43c
b1 a3b0
6 3 1 1
04 2b04
b0 a3b0
66 8166

/* tests/tb_nb_cache.sv */
`timescale 1ns/1ps

module tb_nb_cache;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic us_valid = 1'b0;
	cache_pkg::addr_t us_addr = '0;
	cache_pkg::side_t us_side = '0;
	logic us_stall;
	cache_pkg::addr_t mh_req_addr;
	logic mh_req_valid;
	logic mh_req_stall = 1'b0;
	cache_pkg::rdata_t mh_fill_data = '0;
	logic mh_fill_valid = 1'b0;
	logic mh_fill_stall;
	cache_pkg::rdata_t ds_data;
	cache_pkg::side_t ds_side;
	logic ds_valid;
	logic ds_stall = 1'b0;

	// expected word per block, both words of a block alike
	cache_pkg::rdata_t exp_mem [128];
	// test headers and the flat request list
	int hdr_num [$];
	int hdr_cnt [$];
	int hdr_ds [$];
	int hdr_mh [$];
	cache_pkg::addr_t req_addr [$];
	// miss handler model, requests in arrival order with due cycle
	cache_pkg::addr_t fill_q [$];
	int fill_due [$];
	logic ds_en = 1'b0;
	logic mh_en = 1'b0;
	logic test_end = 1'b0;
	int test_num = 0;
	int seed = 32'h552b920c;
	int rnd;
	int cycles = 0;
	int limit = 0;
	logic [15:0] pending;
	int tests_passed;
	int tests_failed;

	nb_cache #(.FIFO_DEPTH(4)) dut_i (.*);

	cache_checker chk_i (.*);

	always #20 clk = ~clk;

	// cycle budget grows with the number of requests
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, the cache stopped answering", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// miss handler model plus random stalls
	always @(posedge clk) begin
		if (!rst) begin
			if (mh_fill_valid && !mh_fill_stall) begin
				void'(fill_q.pop_front());
				void'(fill_due.pop_front());
			end
			if (mh_req_valid && !mh_req_stall) begin
				rnd = $random(seed);
				fill_q.push_back(mh_req_addr);
				// fill delay of 2 to 8 cycles
				fill_due.push_back(cycles + 2 + (rnd & 32'h7fffffff) % 7);
			end
		end
		#2;
		rnd = $random(seed);
		ds_stall = ds_en & rnd[0];
		mh_req_stall = mh_en & rnd[1];
		// only the oldest request may be answered
		if (fill_q.size() > 0 && fill_due[0] <= cycles) begin
			mh_fill_valid = 1'b1;
			mh_fill_data = exp_mem[fill_q[0][7:1]];
		end else begin
			mh_fill_valid = 1'b0;
		end
	end

	task automatic read_input(output bit ok);
		int fd;
		int n;
		int a;
		int b;
		int c;
		int d;
		int left;
		string line;
		left = 0;
		fd = $fopen("tests/cache_input.dat", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line.substr(0, 1) == "//")
					continue;
				if (left == 0) begin
					n = $sscanf(line, "%d %d %d %d", a, b, c, d);
					if (n != 4)
						ok = 1'b0;
					hdr_num.push_back(a);
					hdr_cnt.push_back(b);
					hdr_ds.push_back(c);
					hdr_mh.push_back(d);
					left = b;
				end else begin
					n = $sscanf(line, "%h %h", a, b);
					if (n != 2)
						ok = 1'b0;
					req_addr.push_back(a[7:0]);
					exp_mem[a[7:1]] = b[15:0];
					left--;
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		int k;
		int drain;
		logic [3:0] side;
		bit ok;
		k = 0;
		side = '0;
		read_input(ok);
		if (!ok) begin
			$display("could not read tests/cache_input.dat");
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			limit = 40 * req_addr.size() + 200;
			repeat (2) @(posedge clk);
			#2;
			rst = 1'b0;
			foreach (hdr_num[t]) begin
				test_num = hdr_num[t];
				ds_en = hdr_ds[t][0];
				mh_en = hdr_mh[t][0];
				for (int r = 0; r < hdr_cnt[t]; r++) begin
					// side tag still in use, hold off
					while (pending[side]) begin
						us_valid = 1'b0;
						@(posedge clk);
						#2;
					end
					us_valid = 1'b1;
					us_addr = req_addr[k];
					us_side = side;
					@(posedge clk);
					while (us_stall)
						@(posedge clk);
					#2;
					k++;
					side = side + 1'b1;
				end
				us_valid = 1'b0;
				// let the responses drain
				drain = 0;
				while (pending != '0 && drain < 200) begin
					@(posedge clk);
					#2;
					drain++;
				end
				test_end = 1'b1;
				@(posedge clk);
				#2;
				test_end = 1'b0;
			end
			$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
			if (tests_failed == 0 && tests_passed == hdr_num.size())
				$display("TEST RESULT: PASS");
			else
				$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule
